//--- Bender.yml
package:
  name: vertex_accu

sources:
  # shared package first
  - common/gnn_accu_pkg.sv
  - vertex_accu/vertex_bank.sv
  - hw/bank_dispatch.sv
  - hw/output_grant_arbiter.sv
  - hw/vertex_accu_top.sv
  - target: test
    files:
      - test/tb_vertex_accu_top.sv

//--- common/gnn_accu_pkg.sv
package gnn_accu_pkg;

    // bank array size
    localparam int NUM_BANKS = 4;

    // feature slots held by one bank
    localparam int MAX_FV_NUM = 8;

    // width of a single feature value
    localparam int FV_SIZE = 8;

    // node id range and width
    localparam int MAX_NODE_ID = 256;
    localparam int NODE_ID_W = $clog2(MAX_NODE_ID);

    // one extra bit lets a full bank count fit in the feature index
    localparam int FV_CNT_W = $clog2(MAX_FV_NUM) + 1;

    // bank index width
    localparam int BANK_SEL_W = $clog2(NUM_BANKS);

    // two features per output beat
    localparam int OUT_DATA_W = 2 * FV_SIZE;

    typedef logic [BANK_SEL_W-1:0] bank_sel_t;

    // one input beat from the vertex PE
    typedef struct packed {
        logic [FV_SIZE-1:0]   data;
        logic [NODE_ID_W-1:0] node_id;
    } vertex_data_t;

    // per-beat stream strobes
    typedef struct packed {
        logic sos;
        logic eos;
        logic change;
    } vertex_cntl_t;

    // one output beat with the low feature in the low byte
    typedef struct packed {
        logic                  req;
        logic                  grant_valid;
        logic                  sos;
        logic                  eos;
        logic [NODE_ID_W-1:0]  node_id;
        logic [OUT_DATA_W-1:0] data;
    } out_pkt_t;

endpackage

//--- hw/bank_dispatch.sv
module bank_dispatch (
    input  logic                                clk,
    input  logic                                reset,
    input  gnn_accu_pkg::vertex_data_t          in_data,
    input  gnn_accu_pkg::vertex_cntl_t          in_cntl,
    input  logic [gnn_accu_pkg::NUM_BANKS-1:0]  bank_busy,
    output gnn_accu_pkg::vertex_data_t          bank_data [gnn_accu_pkg::NUM_BANKS],
    output gnn_accu_pkg::vertex_cntl_t          bank_cntl [gnn_accu_pkg::NUM_BANKS],
    output logic                                in_ready
);

    import gnn_accu_pkg::*;

    // stream currently routed to a bank
    logic      active;
    bank_sel_t sel;

    logic [NUM_BANKS-1:0] claim_mask;
    logic [NUM_BANKS-1:0] idle_mask;
    logic                 free_found;
    bank_sel_t            free_sel;
    logic                 route_en;
    bank_sel_t            route_sel;

    always_comb begin
        claim_mask = '0;
        if (active) begin
            claim_mask[sel] = 1'b1;
        end
    end

    assign idle_mask = ~bank_busy & ~claim_mask;
    assign in_ready  = |idle_mask;

    // descending scan so the lowest idle bank wins
    always_comb begin
        free_found = 1'b0;
        free_sel = '0;
        for (int b = NUM_BANKS - 1; b >= 0; b--) begin
            if (idle_mask[b]) begin
                free_found = 1'b1;
                free_sel = bank_sel_t'(b);
            end
        end
    end

    assign route_en  = active | (in_cntl.sos & free_found);
    assign route_sel = active ? sel : free_sel;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_data[b] = '0;
            bank_cntl[b] = '0;
            if (route_en && route_sel == bank_sel_t'(b)) begin
                bank_data[b] = in_data;
                bank_cntl[b] = in_cntl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            sel <= '0;
        end else if (active) begin
            if (in_cntl.eos) begin
                active <= 1'b0;
            end
        end else if (in_cntl.sos && free_found && !in_cntl.eos) begin
            // single-beat streams never latch
            active <= 1'b1;
            sel <= free_sel;
        end
    end

endmodule

//--- hw/output_grant_arbiter.sv
module output_grant_arbiter (
    input  logic                               clk,
    input  logic                               reset,
    input  gnn_accu_pkg::out_pkt_t             bank_pkt [gnn_accu_pkg::NUM_BANKS],
    output logic [gnn_accu_pkg::NUM_BANKS-1:0] bank_grant,
    output gnn_accu_pkg::out_pkt_t             out_pkt
);

    import gnn_accu_pkg::*;

    // rr_ptr holds the bank last granted and stays on the owner while locked
    bank_sel_t rr_ptr;
    logic      grant_lock;

    logic      next_found;
    bank_sel_t next_sel;
    logic      burst_done;

    // search starts one past the last bank served
    always_comb begin
        bank_sel_t cand;
        next_found = 1'b0;
        next_sel = rr_ptr;
        for (int i = 1; i <= NUM_BANKS; i++) begin
            cand = bank_sel_t'((int'(rr_ptr) + i) % NUM_BANKS);
            if (!next_found && bank_pkt[cand].req) begin
                next_found = 1'b1;
                next_sel = cand;
            end
        end
    end

    assign burst_done = grant_lock & bank_pkt[rr_ptr].grant_valid & bank_pkt[rr_ptr].eos;

    always_comb begin
        bank_grant = '0;
        if (grant_lock) begin
            bank_grant[rr_ptr] = 1'b1;
        end
    end

    // granted bank drives the output and req stays internal
    always_comb begin
        out_pkt = '0;
        if (grant_lock) begin
            out_pkt = bank_pkt[rr_ptr];
            out_pkt.req = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant_lock <= 1'b0;
            rr_ptr <= bank_sel_t'(NUM_BANKS - 1);
        end else if (grant_lock) begin
            if (burst_done) begin
                grant_lock <= 1'b0;
            end
        end else if (next_found) begin
            grant_lock <= 1'b1;
            rr_ptr <= next_sel;
        end
    end

endmodule

//--- hw/vertex_accu_top.sv
module vertex_accu_top (
    input  logic                       clk,
    input  logic                       reset,
    input  gnn_accu_pkg::vertex_data_t in_data,
    input  gnn_accu_pkg::vertex_cntl_t in_cntl,
    output logic                       in_ready,
    output gnn_accu_pkg::out_pkt_t     out_pkt
);

    import gnn_accu_pkg::*;

    vertex_data_t         bank_data [NUM_BANKS];
    vertex_cntl_t         bank_cntl [NUM_BANKS];
    out_pkt_t             bank_pkt [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_busy;
    logic [NUM_BANKS-1:0] bank_grant;

    bank_dispatch i_bank_dispatch (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_cntl   (in_cntl),
        .bank_busy (bank_busy),
        .bank_data (bank_data),
        .bank_cntl (bank_cntl),
        .in_ready  (in_ready)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        vertex_bank i_vertex_bank (
            .clk             (clk),
            .reset           (reset),
            .vertex_data_pkt (bank_data[b]),
            .vertex_cntl_pkt (bank_cntl[b]),
            .req_grant       (bank_grant[b]),
            .bank_busy       (bank_busy[b]),
            .outbuff_pkt     (bank_pkt[b])
        );
    end

    output_grant_arbiter i_output_grant_arbiter (
        .clk        (clk),
        .reset      (reset),
        .bank_pkt   (bank_pkt),
        .bank_grant (bank_grant),
        .out_pkt    (out_pkt)
    );

endmodule

//--- test/tb_vertex_accu_top.sv
module tb_vertex_accu_top;

    import gnn_accu_pkg::*;

    localparam int NUM_TESTS = 5;

    logic         clk;
    logic         reset;
    vertex_data_t in_data;
    vertex_cntl_t in_cntl;
    logic         in_ready;
    out_pkt_t     out_pkt;

    integer seed;
    int     mismatch_errors;
    int     other_errors;

    // expected beats in one flat list with per-burst bookkeeping
    out_pkt_t               exp_beats [$];
    int                     exp_start [$];
    int                     exp_len [$];
    logic [NODE_ID_W-1:0]   exp_node [$];
    bit                     exp_used [$];

    // monitor state
    bit in_burst;
    int cur_burst;
    int beat_pos;

    vertex_accu_top i_vertex_accu_top (
        .clk      (clk),
        .reset    (reset),
        .in_data  (in_data),
        .in_cntl  (in_cntl),
        .in_ready (in_ready),
        .out_pkt  (out_pkt)
    );

    always #10 clk = ~clk;

    task automatic check_pkt(input out_pkt_t exp, input out_pkt_t act);
        if (act.req !== exp.req) begin
            $display("MISMATCH out_pkt.req exp %h got %h", exp.req, act.req);
            mismatch_errors++;
        end
        if (act.grant_valid !== exp.grant_valid) begin
            $display("MISMATCH out_pkt.grant_valid exp %h got %h", exp.grant_valid,
                     act.grant_valid);
            mismatch_errors++;
        end
        if (act.sos !== exp.sos) begin
            $display("MISMATCH out_pkt.sos exp %h got %h", exp.sos, act.sos);
            mismatch_errors++;
        end
        if (act.eos !== exp.eos) begin
            $display("MISMATCH out_pkt.eos exp %h got %h", exp.eos, act.eos);
            mismatch_errors++;
        end
        if (act.node_id !== exp.node_id) begin
            $display("MISMATCH out_pkt.node_id exp %h got %h", exp.node_id, act.node_id);
            mismatch_errors++;
        end
        if (act.data !== exp.data) begin
            $display("MISMATCH out_pkt.data exp %h got %h", exp.data, act.data);
            mismatch_errors++;
        end
    endtask

    task automatic check_ready(input logic exp);
        if (in_ready !== exp) begin
            $display("MISMATCH in_ready exp %h got %h", exp, in_ready);
            mismatch_errors++;
        end
    endtask

    function automatic int find_burst(input logic [NODE_ID_W-1:0] node);
        for (int i = 0; i < exp_node.size(); i++) begin
            if (!exp_used[i] && exp_node[i] == node) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int pending_bursts();
        int cnt;
        cnt = 0;
        foreach (exp_used[i]) begin
            if (!exp_used[i]) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    // plays the vertex PE and records the bursts the stream should produce
    task automatic send_stream(input logic [NODE_ID_W-1:0] node, input int n,
                               input int max_rep);
        logic [FV_SIZE-1:0] sums [MAX_FV_NUM];
        logic [FV_SIZE-1:0] d;
        out_pkt_t p;
        int reps;
        int waited;
        foreach (sums[i]) begin
            sums[i] = '0;
        end
        waited = 0;
        @(negedge clk);
        while (!in_ready && waited < 400) begin
            in_data = '0;
            in_cntl = '0;
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("in_ready stayed low, stream for node %h not sent", node);
            other_errors++;
            return;
        end
        for (int f = 0; f < n; f++) begin
            reps = int'($unsigned($random(seed)) % max_rep) + 1;
            for (int r = 0; r < reps; r++) begin
                if (f != 0 || r != 0) begin
                    @(negedge clk);
                end
                d = $random(seed);
                sums[f] = sums[f] + d;
                in_data.data = d;
                in_data.node_id = node;
                in_cntl.sos = (f == 0 && r == 0);
                in_cntl.eos = (f == n - 1 && r == reps - 1);
                in_cntl.change = (r == reps - 1) && (f != n - 1);
            end
        end
        // two features per beat with an odd tail padded by zero
        exp_node.push_back(node);
        exp_start.push_back(exp_beats.size());
        exp_len.push_back((n + 1) / 2);
        exp_used.push_back(1'b0);
        for (int j = 0; j < (n + 1) / 2; j++) begin
            p = '0;
            p.grant_valid = 1'b1;
            p.sos = (j == 0);
            p.eos = (j == (n + 1) / 2 - 1);
            p.node_id = node;
            p.data[FV_SIZE-1:0] = sums[2*j];
            p.data[OUT_DATA_W-1:FV_SIZE] = (2 * j + 1 < n) ? sums[2*j+1] : '0;
            exp_beats.push_back(p);
        end
    endtask

    task automatic clear_inputs();
        @(negedge clk);
        in_data = '0;
        in_cntl = '0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((pending_bursts() != 0 || in_burst) && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        foreach (exp_used[i]) begin
            if (!exp_used[i]) begin
                $display("no burst seen for node %h", exp_node[i]);
                other_errors++;
                exp_used[i] = 1'b1;
            end
        end
        // bank goes idle one cycle after its last beat
        repeat (2) @(negedge clk);
    endtask

    // output monitor sampling values held through the previous cycle
    always @(posedge clk) begin
        if (!reset && out_pkt.grant_valid) begin
            if (out_pkt.sos) begin
                if (in_burst) begin
                    $display("burst for node %h started inside another burst",
                             out_pkt.node_id);
                    other_errors++;
                end
                cur_burst = find_burst(out_pkt.node_id);
                beat_pos = 0;
                in_burst = 1'b1;
                if (cur_burst < 0) begin
                    $display("unexpected burst for node %h", out_pkt.node_id);
                    other_errors++;
                end else begin
                    exp_used[cur_burst] = 1'b1;
                end
            end
            if (!in_burst) begin
                $display("output beat seen without a burst start");
                other_errors++;
            end else if (cur_burst >= 0) begin
                if (beat_pos < exp_len[cur_burst]) begin
                    check_pkt(exp_beats[exp_start[cur_burst] + beat_pos], out_pkt);
                end else begin
                    $display("extra beat in burst for node %h", out_pkt.node_id);
                    other_errors++;
                end
            end
            beat_pos++;
            if (out_pkt.eos) begin
                if (in_burst && cur_burst >= 0 && beat_pos < exp_len[cur_burst]) begin
                    $display("burst for node %h ended early", out_pkt.node_id);
                    other_errors++;
                end
                in_burst = 1'b0;
            end
        end else if (!reset) begin
            if (in_burst) begin
                $display("burst broke off before its last beat");
                other_errors++;
                in_burst = 1'b0;
            end
            // no granted bank leaves the output all zero
            check_pkt('0, out_pkt);
        end
    end

    task automatic reset_state();
        check_ready(1'b1);
        check_pkt('0, out_pkt);
    endtask

    task automatic single_beat_stream();
        send_stream(8'h11, 1, 1);
        clear_inputs();
        wait_drain();
    endtask

    task automatic accumulate_streams();
        // odd then even feature count
        send_stream(8'h21, 5, 4);
        clear_inputs();
        wait_drain();
        send_stream(8'h22, 8, 4);
        clear_inputs();
        wait_drain();
    endtask

    task automatic concurrent_banks();
        for (int s = 0; s < NUM_BANKS; s++) begin
            send_stream(8'h30 + s, int'($unsigned($random(seed)) % MAX_FV_NUM) + 1, 3);
        end
        clear_inputs();
        wait_drain();
    endtask

    task automatic fill_and_recover();
        int waited;
        // long first stream keeps its bank draining while the others fill up
        send_stream(8'h40, 8, 1);
        send_stream(8'h41, 1, 1);
        send_stream(8'h42, 1, 1);
        send_stream(8'h43, 1, 1);
        clear_inputs();
        check_ready(1'b0);
        waited = 0;
        while (!in_ready && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        check_ready(1'b1);
        send_stream(8'h44, 5, 2);
        clear_inputs();
        wait_drain();
    endtask

    initial begin
        #(NUM_TESTS * 400 * 20);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed = 32'heb59_d8ea;
        mismatch_errors = 0;
        other_errors = 0;
        in_burst = 1'b0;
        cur_burst = -1;
        beat_pos = 0;
        clk = 1'b0;
        reset = 1'b1;
        in_data = '0;
        in_cntl = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        reset_state();
        single_beat_stream();
        accumulate_streams();
        concurrent_banks();
        fill_and_recover();
        $display("errors: %0d mismatches, %0d other failures", mismatch_errors,
                 other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- vertex_accu/vertex_bank.sv
module vertex_bank (
    input  logic                       clk,
    input  logic                       reset,
    input  gnn_accu_pkg::vertex_data_t vertex_data_pkt,
    input  gnn_accu_pkg::vertex_cntl_t vertex_cntl_pkt,
    input  logic                       req_grant,
    output logic                       bank_busy,
    output gnn_accu_pkg::out_pkt_t     outbuff_pkt
);

    import gnn_accu_pkg::*;

    typedef enum logic [1:0] {
        s_idle      = 2'd0,
        s_stream_in = 2'd1,
        s_out_wait  = 2'd2,
        s_out_burst = 2'd3
    } state_t;

    state_t state;

    // accumulated feature sums
    logic [MAX_FV_NUM-1:0][FV_SIZE-1:0] slots;

    // feature index while streaming, beat pointer while draining
    logic [FV_CNT_W-1:0] cnt;
    logic [FV_CNT_W-1:0] cnt_step;
    logic [FV_CNT_W-1:0] fv_num;
    logic [NODE_ID_W-1:0] cur_node_id;

    logic [FV_CNT_W-2:0] slot_lo;
    logic [FV_CNT_W-2:0] slot_hi;
    logic last_beat;
    logic hi_valid;
    logic [OUT_DATA_W-1:0] beat_data;

    assign bank_busy = (state != s_idle);

    assign slot_lo  = cnt[FV_CNT_W-2:0];
    assign slot_hi  = slot_lo + 1'b1;
    assign cnt_step = cnt + FV_CNT_W'(2);

    // last pair once two more features reach the count
    assign last_beat = (cnt_step >= fv_num);
    // odd count leaves the high half of the final beat empty
    assign hi_valid  = (cnt_step <= fv_num);

    assign beat_data = {hi_valid ? slots[slot_hi] : {FV_SIZE{1'b0}}, slots[slot_lo]};

    always_comb begin
        outbuff_pkt = '0;
        outbuff_pkt.node_id = cur_node_id;
        case (state)
            s_idle: begin
                // single-beat stream asks for the output right away
                outbuff_pkt.req = vertex_cntl_pkt.sos & vertex_cntl_pkt.eos;
            end
            s_stream_in: begin
                outbuff_pkt.req = vertex_cntl_pkt.eos;
            end
            s_out_wait: begin
                if (req_grant) begin
                    outbuff_pkt.grant_valid = 1'b1;
                    outbuff_pkt.sos = 1'b1;
                    outbuff_pkt.eos = last_beat;
                    outbuff_pkt.data = beat_data;
                end else begin
                    outbuff_pkt.req = 1'b1;
                end
            end
            s_out_burst: begin
                outbuff_pkt.grant_valid = 1'b1;
                outbuff_pkt.eos = last_beat;
                outbuff_pkt.data = beat_data;
            end
            default: begin
                outbuff_pkt.req = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
            slots <= '0;
            cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (vertex_cntl_pkt.sos) begin
                        slots[slot_lo] <= slots[slot_lo] + vertex_data_pkt.data;
                        if (vertex_cntl_pkt.eos) begin
                            state <= s_out_wait;
                        end else begin
                            state <= s_stream_in;
                            if (vertex_cntl_pkt.change) begin
                                cnt <= cnt + 1'b1;
                            end
                        end
                    end
                end
                s_stream_in: begin
                    slots[slot_lo] <= slots[slot_lo] + vertex_data_pkt.data;
                    if (vertex_cntl_pkt.eos) begin
                        state <= s_out_wait;
                        cnt <= '0;
                    end else if (vertex_cntl_pkt.change) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                s_out_wait, s_out_burst: begin
                    // stall in out_wait until the arbiter hands over the output
                    if (state == s_out_burst || req_grant) begin
                        if (last_beat) begin
                            state <= s_idle;
                            slots <= '0;
                            cnt <= '0;
                        end else begin
                            state <= s_out_burst;
                            cnt <= cnt_step;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // node id and feature count are captured once per stream
    always_ff @(posedge clk) begin
        if (state == s_idle && vertex_cntl_pkt.sos) begin
            cur_node_id <= vertex_data_pkt.node_id;
        end
        if ((state == s_idle && vertex_cntl_pkt.sos) || state == s_stream_in) begin
            if (vertex_cntl_pkt.eos) begin
                fv_num <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- vertex_accu_top.f
common/gnn_accu_pkg.sv
vertex_accu/vertex_bank.sv
hw/bank_dispatch.sv
hw/output_grant_arbiter.sv
hw/vertex_accu_top.sv
test/tb_vertex_accu_top.sv
